//--- hw/kmeans_pkg.sv
package kmeans_pkg;

  // Sizes
  localparam int DATA_W     = 8;
  localparam int NUM_K      = 5;
  localparam int K_W        = 3;
  localparam int NUM_DIM    = 2;
  localparam int MAX_POINTS = 256;
  localparam int ADDR_W     = 8;
  localparam int CNT_W      = 9;
  localparam int SQR_W      = 16;
  localparam int DIST_W     = 17;
  localparam int ACC_W      = 16;
  localparam int PIPE_LAT   = 6;
  localparam int APB_AW     = 12;
  localparam int APB_DW     = 32;

  // Register map, byte offsets
  localparam logic [APB_AW-1:0] REG_CTRL       = 12'h000;
  localparam logic [APB_AW-1:0] REG_STATUS     = 12'h004;
  localparam logic [APB_AW-1:0] REG_NPTS       = 12'h008;
  localparam logic [APB_AW-1:0] REG_CENT_BASE  = 12'h010;
  localparam logic [APB_AW-1:0] REG_SUM0_BASE  = 12'h040;
  localparam logic [APB_AW-1:0] REG_SUM1_BASE  = 12'h060;
  localparam logic [APB_AW-1:0] REG_CNT_BASE   = 12'h080;
  localparam logic [APB_AW-1:0] REG_POINT_BASE = 12'h400;

  // One point or one centroid, d0 in the low byte
  typedef struct packed {
    logic [DATA_W-1:0] d1;
    logic [DATA_W-1:0] d0;
  } point_t;

  typedef point_t [NUM_K-1:0] centroid_set_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // Pipeline output
  typedef struct packed {
    logic           valid;
    logic [K_W-1:0] idx;
    point_t         pt;
  } assign_t;

  typedef struct packed {
    logic [ACC_W-1:0] sum0;
    logic [ACC_W-1:0] sum1;
    logic [CNT_W-1:0] count;
  } cluster_stats_t;

  typedef cluster_stats_t [NUM_K-1:0] stats_set_t;

endpackage

//--- hw/kmeans_apb_regs.sv
`timescale 1ns/1ps

module kmeans_apb_regs import kmeans_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  apb_req_t          i_apb,
  output apb_rsp_t          o_apb,
  output logic              o_start,
  output logic [CNT_W-1:0]  o_npts,
  output centroid_set_t     o_centroids,
  output logic              o_pt_we,
  output logic [ADDR_W-1:0] o_pt_addr,
  output point_t            o_pt_data,
  input  stats_set_t        i_stats,
  input  logic              i_done
);

  logic busy;
  logic done;
  logic access;
  logic wr_en;
  logic hit_ctrl, hit_status, hit_npts, hit_cent;
  logic hit_sum0, hit_sum1, hit_cnt, hit_point;
  logic cfg_hit;
  logic mapped;
  logic [APB_AW-1:0] cent_word, sum0_word, sum1_word, cnt_word, pt_word;

  // Word index relative to a window base, wraps to a large value below the base
  function automatic logic [APB_AW-1:0] word_off(input logic [APB_AW-1:0] addr,
                                                 input logic [APB_AW-1:0] base);
    logic [APB_AW-1:0] off;
    off = addr - base;
    return off >> 2;
  endfunction

  assign access = i_apb.psel & i_apb.penable;
  assign wr_en  = access & i_apb.pwrite;

  assign cent_word = word_off(i_apb.paddr, REG_CENT_BASE);
  assign sum0_word = word_off(i_apb.paddr, REG_SUM0_BASE);
  assign sum1_word = word_off(i_apb.paddr, REG_SUM1_BASE);
  assign cnt_word  = word_off(i_apb.paddr, REG_CNT_BASE);
  assign pt_word   = word_off(i_apb.paddr, REG_POINT_BASE);

  assign hit_ctrl   = (i_apb.paddr == REG_CTRL);
  assign hit_status = (i_apb.paddr == REG_STATUS);
  assign hit_npts   = (i_apb.paddr == REG_NPTS);
  assign hit_cent   = (cent_word < NUM_K);
  assign hit_sum0   = (sum0_word < NUM_K);
  assign hit_sum1   = (sum1_word < NUM_K);
  assign hit_cnt    = (cnt_word < NUM_K);
  assign hit_point  = (pt_word < MAX_POINTS);

  // Configuration is frozen while a pass runs
  assign cfg_hit = hit_ctrl | hit_npts | hit_cent | hit_point;
  assign mapped  = cfg_hit | hit_status | hit_sum0 | hit_sum1 | hit_cnt;

  assign o_apb.pready  = 1'b1;
  assign o_apb.pslverr = access & (~mapped | (wr_en & cfg_hit & busy));

  // Point memory is written straight from the access cycle
  assign o_pt_we   = wr_en & hit_point & ~busy;
  assign o_pt_addr = pt_word[ADDR_W-1:0];
  assign o_pt_data = point_t'(i_apb.pwdata[2*DATA_W-1:0]);

  always_comb begin
    o_apb.prdata = '0;
    if (hit_status) begin
      o_apb.prdata = {{(APB_DW-2){1'b0}}, done, busy};
    end else if (hit_npts) begin
      o_apb.prdata = APB_DW'(o_npts);
    end else if (hit_cent) begin
      o_apb.prdata = APB_DW'(o_centroids[cent_word[K_W-1:0]]);
    end else if (hit_sum0) begin
      o_apb.prdata = APB_DW'(i_stats[sum0_word[K_W-1:0]].sum0);
    end else if (hit_sum1) begin
      o_apb.prdata = APB_DW'(i_stats[sum1_word[K_W-1:0]].sum1);
    end else if (hit_cnt) begin
      o_apb.prdata = APB_DW'(i_stats[cnt_word[K_W-1:0]].count);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_start     <= 1'b0;
      busy        <= 1'b0;
      done        <= 1'b0;
      o_npts      <= '0;
      o_centroids <= '0;
    end else begin
      o_start <= 1'b0;
      if (i_done) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
      if (wr_en && !busy) begin
        if (hit_ctrl && i_apb.pwdata[0]) begin
          o_start <= 1'b1;
          busy    <= 1'b1;
          done    <= 1'b0;
        end
        // Clamp to the memory depth
        if (hit_npts) begin
          o_npts <= (i_apb.pwdata > MAX_POINTS) ? CNT_W'(MAX_POINTS)
                                                : i_apb.pwdata[CNT_W-1:0];
        end
        if (hit_cent) begin
          o_centroids[cent_word[K_W-1:0]] <= point_t'(i_apb.pwdata[2*DATA_W-1:0]);
        end
      end
    end
  end

endmodule

//--- hw/kmeans_point_scan.sv
`timescale 1ns/1ps

module kmeans_point_scan import kmeans_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_start,
  input  logic [CNT_W-1:0]  i_npts,
  input  logic              i_pt_we,
  input  logic [ADDR_W-1:0] i_pt_addr,
  input  point_t            i_pt_data,
  output logic              o_valid,
  output point_t            o_pt
);

  point_t mem [MAX_POINTS];

  logic [ADDR_W-1:0] next_addr;
  logic [CNT_W-1:0]  remain;
  logic              rd_en;
  logic [ADDR_W-1:0] rd_addr;

  // Point 0 is read in the start cycle itself, the counter covers the rest
  assign rd_en   = i_start ? (i_npts != '0) : (remain != '0);
  assign rd_addr = i_start ? '0 : next_addr;

  always_ff @(posedge clk) begin
    if (i_pt_we) begin
      mem[i_pt_addr] <= i_pt_data;
    end
    if (rd_en) begin
      o_pt <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid   <= 1'b0;
      remain    <= '0;
      next_addr <= '0;
    end else begin
      o_valid <= rd_en;
      if (i_start) begin
        remain    <= (i_npts == '0) ? '0 : i_npts - CNT_W'(1);
        next_addr <= ADDR_W'(1);
      end else if (remain != '0) begin
        remain    <= remain - CNT_W'(1);
        // Wraps to 0 after the last of 256 points, harmless since remain hits 0
        next_addr <= next_addr + ADDR_W'(1);
      end
    end
  end

endmodule

//--- hw/kmeans_distance_pipe.sv
`timescale 1ns/1ps

module kmeans_distance_pipe import kmeans_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          i_valid,
  input  point_t        i_pt,
  input  centroid_set_t i_centroids,
  output assign_t       o_assign
);

  logic [DATA_W-1:0] diff0_s1 [NUM_K];
  logic [DATA_W-1:0] diff1_s1 [NUM_K];
  logic [SQR_W-1:0]  sq0_s2   [NUM_K];
  logic [SQR_W-1:0]  sq1_s2   [NUM_K];
  logic [DIST_W-1:0] dist_s3  [NUM_K];

  // Comparison tree, 5 -> 3 -> 2 -> 1
  logic [DIST_W-1:0] best_s4 [3];
  logic [K_W-1:0]    idx_s4  [3];
  logic [DIST_W-1:0] best_s5 [2];
  logic [K_W-1:0]    idx_s5  [2];
  logic [K_W-1:0]    idx_s6;

  logic [PIPE_LAT-1:0] valid_q;
  point_t              pt_q [PIPE_LAT];

  function automatic logic [DATA_W-1:0] abs_diff(input logic [DATA_W-1:0] a,
                                                 input logic [DATA_W-1:0] b);
    return (a > b) ? a - b : b - a;
  endfunction

  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_K; k++) begin
      diff0_s1[k] <= abs_diff(i_pt.d0, i_centroids[k].d0);
      diff1_s1[k] <= abs_diff(i_pt.d1, i_centroids[k].d1);
      sq0_s2[k]   <= SQR_W'(diff0_s1[k]) * SQR_W'(diff0_s1[k]);
      sq1_s2[k]   <= SQR_W'(diff1_s1[k]) * SQR_W'(diff1_s1[k]);
      dist_s3[k]  <= DIST_W'(sq0_s2[k]) + DIST_W'(sq1_s2[k]);
    end

    // Left operand always has the lower index, so <= keeps it on a tie
    best_s4[0] <= (dist_s3[0] <= dist_s3[1]) ? dist_s3[0] : dist_s3[1];
    idx_s4[0]  <= (dist_s3[0] <= dist_s3[1]) ? K_W'(0) : K_W'(1);
    best_s4[1] <= (dist_s3[2] <= dist_s3[3]) ? dist_s3[2] : dist_s3[3];
    idx_s4[1]  <= (dist_s3[2] <= dist_s3[3]) ? K_W'(2) : K_W'(3);
    best_s4[2] <= dist_s3[NUM_K-1];
    idx_s4[2]  <= K_W'(NUM_K-1);

    best_s5[0] <= (best_s4[0] <= best_s4[1]) ? best_s4[0] : best_s4[1];
    idx_s5[0]  <= (best_s4[0] <= best_s4[1]) ? idx_s4[0] : idx_s4[1];
    best_s5[1] <= best_s4[2];
    idx_s5[1]  <= idx_s4[2];

    idx_s6 <= (best_s5[0] <= best_s5[1]) ? idx_s5[0] : idx_s5[1];

    // Point rides along with its distance
    pt_q[0] <= i_pt;
    for (int i = 1; i < PIPE_LAT; i++) begin
      pt_q[i] <= pt_q[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[PIPE_LAT-2:0], i_valid};
    end
  end

  assign o_assign.valid = valid_q[PIPE_LAT-1];
  assign o_assign.idx   = idx_s6;
  assign o_assign.pt    = pt_q[PIPE_LAT-1];

endmodule

//--- hw/kmeans_cluster_acc.sv
`timescale 1ns/1ps

module kmeans_cluster_acc import kmeans_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_start,
  input  logic [CNT_W-1:0] i_npts,
  input  assign_t          i_assign,
  output stats_set_t       o_stats,
  output logic             o_done
);

  logic [CNT_W-1:0] accepted;
  logic [CNT_W-1:0] accepted_nxt;

  assign accepted_nxt = accepted + CNT_W'(1);

  // NPTS cannot change during a pass, so it is compared directly
  always_ff @(posedge clk) begin
    if (rst) begin
      o_stats  <= '0;
      accepted <= '0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        o_stats  <= '0;
        accepted <= '0;
        // Empty pass finishes right away
        o_done   <= (i_npts == '0);
      end else if (i_assign.valid) begin
        o_stats[i_assign.idx].sum0  <= o_stats[i_assign.idx].sum0 + ACC_W'(i_assign.pt.d0);
        o_stats[i_assign.idx].sum1  <= o_stats[i_assign.idx].sum1 + ACC_W'(i_assign.pt.d1);
        o_stats[i_assign.idx].count <= o_stats[i_assign.idx].count + CNT_W'(1);
        accepted <= accepted_nxt;
        o_done   <= (accepted_nxt == i_npts);
      end
    end
  end

endmodule

//--- hw/kmeans_top.sv
`timescale 1ns/1ps

module kmeans_top import kmeans_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  apb_req_t i_apb,
  output apb_rsp_t o_apb
);

  logic              start;
  logic [CNT_W-1:0]  npts;
  centroid_set_t     centroids;
  logic              pt_we;
  logic [ADDR_W-1:0] pt_addr;
  point_t            pt_data;
  logic              scan_valid;
  point_t            scan_pt;
  assign_t           pipe_out;
  stats_set_t        stats;
  logic              acc_done;

  kmeans_apb_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .i_apb       (i_apb),
    .o_apb       (o_apb),
    .o_start     (start),
    .o_npts      (npts),
    .o_centroids (centroids),
    .o_pt_we     (pt_we),
    .o_pt_addr   (pt_addr),
    .o_pt_data   (pt_data),
    .i_stats     (stats),
    .i_done      (acc_done)
  );

  kmeans_point_scan u_scan (
    .clk       (clk),
    .rst       (rst),
    .i_start   (start),
    .i_npts    (npts),
    .i_pt_we   (pt_we),
    .i_pt_addr (pt_addr),
    .i_pt_data (pt_data),
    .o_valid   (scan_valid),
    .o_pt      (scan_pt)
  );

  kmeans_distance_pipe u_pipe (
    .clk         (clk),
    .rst         (rst),
    .i_valid     (scan_valid),
    .i_pt        (scan_pt),
    .i_centroids (centroids),
    .o_assign    (pipe_out)
  );

  kmeans_cluster_acc u_acc (
    .clk      (clk),
    .rst      (rst),
    .i_start  (start),
    .i_npts   (npts),
    .i_assign (pipe_out),
    .o_stats  (stats),
    .o_done   (acc_done)
  );

endmodule

//--- test/kmeans_tb.sv
`timescale 1ns/1ps

module kmeans_tb import kmeans_pkg::*;;

  localparam int CYCLE_LIMIT = 20000;

  logic     clk;
  logic     rst;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  int       cycles = 0;

  // Reference copy of the configuration and the expected results
  logic [2*DATA_W-1:0] pts   [MAX_POINTS];
  logic [2*DATA_W-1:0] cents [NUM_K];
  int exp_sum0 [NUM_K];
  int exp_sum1 [NUM_K];
  int exp_cnt  [NUM_K];

  kmeans_top dut0 (
    .clk   (clk),
    .rst   (rst),
    .i_apb (apb_req),
    .o_apb (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_error(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Errors found");
      $fatal(1, "timeout");
    end
  end

  // Every access cycle must complete at once
  assert property (@(posedge clk) disable iff (rst)
    (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
    else report_error("pready low in an APB access cycle");

  // One APB transfer with the response sampled mid access cycle
  task automatic apb_transfer(input logic wr, input logic [APB_AW-1:0] addr,
                              input logic [APB_DW-1:0] wdata, input logic exp_err,
                              output logic [APB_DW-1:0] rdata);
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk);
    rdata = apb_rsp.prdata;
    assert (apb_rsp.pslverr == exp_err)
      else report_error($sformatf("pslverr %0b at 0x%03h (write %0b), expected %0b",
                                  apb_rsp.pslverr, addr, wr, exp_err));
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                           input logic exp_err);
    logic [APB_DW-1:0] unused;
    apb_transfer(1'b1, addr, data, exp_err, unused);
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                          input logic exp_err);
    apb_transfer(1'b0, addr, '0, exp_err, data);
  endtask

  task automatic read_expect(input logic [APB_AW-1:0] addr, input int exp, input string what);
    logic [APB_DW-1:0] data;
    apb_read(addr, data, 1'b0);
    assert (data == APB_DW'(exp))
      else report_error($sformatf("%s reads %0d, expected %0d", what, data, exp));
  endtask

  task automatic write_point(input int i, input logic [2*DATA_W-1:0] value);
    pts[i] = value;
    apb_write(REG_POINT_BASE + APB_AW'(4 * i), APB_DW'(value), 1'b0);
  endtask

  task automatic write_centroid(input int k, input logic [2*DATA_W-1:0] value);
    cents[k] = value;
    apb_write(REG_CENT_BASE + APB_AW'(4 * k), APB_DW'(value), 1'b0);
  endtask

  task automatic load_random(input int n);
    for (int i = 0; i < n; i++) begin
      write_point(i, 16'($urandom()));
    end
    for (int k = 0; k < NUM_K; k++) begin
      write_centroid(k, 16'($urandom()));
    end
  endtask

  task automatic wait_done();
    logic [APB_DW-1:0] status;
    status = '0;
    while (status[1] == 1'b0) begin
      apb_read(REG_STATUS, status, 1'b0);
    end
    assert (status[0] == 1'b0) else report_error("busy still set together with done");
  endtask

  // Nearest centroid by squared distance where a strict compare keeps the lower index
  function automatic void compute_expected(input int n);
    int dx;
    int dy;
    int d;
    int best_d;
    int best_k;
    for (int k = 0; k < NUM_K; k++) begin
      exp_sum0[k] = 0;
      exp_sum1[k] = 0;
      exp_cnt[k]  = 0;
    end
    for (int i = 0; i < n; i++) begin
      best_d = 0;
      best_k = 0;
      for (int k = 0; k < NUM_K; k++) begin
        dx = int'(pts[i][DATA_W-1:0]) - int'(cents[k][DATA_W-1:0]);
        dy = int'(pts[i][2*DATA_W-1:DATA_W]) - int'(cents[k][2*DATA_W-1:DATA_W]);
        d  = dx * dx + dy * dy;
        if (k == 0 || d < best_d) begin
          best_d = d;
          best_k = k;
        end
      end
      exp_sum0[best_k] += int'(pts[i][DATA_W-1:0]);
      exp_sum1[best_k] += int'(pts[i][2*DATA_W-1:DATA_W]);
      exp_cnt[best_k]  += 1;
    end
  endfunction

  task automatic check_results(input int n);
    logic [APB_DW-1:0] data;
    int total;
    compute_expected(n);
    total = 0;
    for (int k = 0; k < NUM_K; k++) begin
      read_expect(REG_SUM0_BASE + APB_AW'(4 * k), exp_sum0[k], $sformatf("sum0[%0d]", k));
      read_expect(REG_SUM1_BASE + APB_AW'(4 * k), exp_sum1[k], $sformatf("sum1[%0d]", k));
      apb_read(REG_CNT_BASE + APB_AW'(4 * k), data, 1'b0);
      assert (data == APB_DW'(exp_cnt[k]))
        else report_error($sformatf("count[%0d] reads %0d, expected %0d", k, data, exp_cnt[k]));
      total += int'(data);
    end
    assert (total == n) else report_error($sformatf("counts add up to %0d, not %0d", total, n));
  endtask

  task automatic run_pass(input int n);
    apb_write(REG_NPTS, APB_DW'(n), 1'b0);
    apb_write(REG_CTRL, 32'h1, 1'b0);
    wait_done();
    check_results(n);
  endtask

  initial begin
    logic [APB_DW-1:0] data;
    void'($urandom(32'hc54b81ed));
    apb_req = '0;
    rst     = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // Everything reads zero out of reset
    read_expect(REG_STATUS, 0, "STATUS");
    read_expect(REG_NPTS, 0, "NPTS");
    for (int k = 0; k < NUM_K; k++) begin
      read_expect(REG_CENT_BASE + APB_AW'(4 * k), 0, $sformatf("centroid[%0d]", k));
      read_expect(REG_SUM0_BASE + APB_AW'(4 * k), 0, $sformatf("sum0[%0d]", k));
      read_expect(REG_SUM1_BASE + APB_AW'(4 * k), 0, $sformatf("sum1[%0d]", k));
      read_expect(REG_CNT_BASE + APB_AW'(4 * k), 0, $sformatf("count[%0d]", k));
    end

    load_random(64);
    run_pass(64);

    // Centroids 1 and 3 coincide and every point lies next to them
    write_centroid(0, 16'h0000);
    write_centroid(1, 16'h6464);
    write_centroid(2, 16'hfafa);
    write_centroid(3, 16'h6464);
    write_centroid(4, 16'h00fa);
    for (int i = 0; i < 32; i++) begin
      write_point(i, {8'(90 + $urandom_range(20)), 8'(90 + $urandom_range(20))});
    end
    run_pass(32);
    read_expect(REG_CNT_BASE + APB_AW'(4), 32, "tie count[1]");
    read_expect(REG_CNT_BASE + APB_AW'(12), 0, "tie count[3]");

    // Configuration writes bounce while a pass runs
    load_random(64);
    apb_write(REG_NPTS, 32'd64, 1'b0);
    apb_write(REG_CTRL, 32'h1, 1'b0);
    read_expect(REG_STATUS, 1, "STATUS during pass");
    apb_write(REG_CENT_BASE, 32'h0000_1234, 1'b1);
    apb_write(REG_NPTS, 32'd3, 1'b1);
    // Last point of the pass is read well after this write
    apb_write(REG_POINT_BASE + APB_AW'(4 * 63), 32'h0000_abcd, 1'b1);
    apb_write(REG_CTRL, 32'h1, 1'b1);
    wait_done();
    check_results(64);
    read_expect(REG_CENT_BASE, int'(cents[0]), "centroid[0] after rejected write");
    read_expect(REG_NPTS, 64, "NPTS after rejected write");

    // Full memory with new centroids and NPTS clamped to the depth
    load_random(256);
    apb_write(REG_NPTS, 32'd300, 1'b0);
    read_expect(REG_NPTS, 256, "clamped NPTS");
    apb_write(REG_CTRL, 32'h1, 1'b0);
    wait_done();
    check_results(256);
    run_pass(0);

    // Unmapped addresses
    apb_write(12'h00c, 32'h1, 1'b1);
    apb_read(12'h024, data, 1'b1);
    apb_read(12'h094, data, 1'b1);
    apb_read(12'h3fc, data, 1'b1);
    apb_read(12'h800, data, 1'b1);
    apb_read(REG_POINT_BASE + APB_AW'(4), data, 1'b0);
    assert (data == '0) else report_error($sformatf("point read returns 0x%08h", data));

    $display("No errors");
    $finish;
  end

endmodule

//--- flist.f
hw/kmeans_pkg.sv
hw/kmeans_apb_regs.sv
hw/kmeans_point_scan.sv
hw/kmeans_distance_pipe.sv
hw/kmeans_cluster_acc.sv
hw/kmeans_top.sv
test/kmeans_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the k-means testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module kmeans_tb \
  -f flist.f -o kmeans_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/kmeans_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Errors found" "$SIM_LOG"; then
  echo "Simulation reported failures"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
